/* design/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ------------------------------------------------------------
// Global widths of the address-generation pipeline
// ------------------------------------------------------------

// Data and address width of the core
`define LSU_XLEN 64

// Tag that identifies the load/store buffer entry
`define LSU_TAG_W 4

// Raw immediate as found in the I-type and S-type formats
`define LSU_IMM_W 12

`endif

/* design/lsu_pkg.sv */
`include "lsu_defines.svh"

package lsu_pkg;

    // ------------------------------------------------------------
    // Width types
    // ------------------------------------------------------------

    // Address or data word
    typedef logic [`LSU_XLEN-1:0] xlen_t;

    // Load/store buffer tag
    typedef logic [`LSU_TAG_W-1:0] tag_t;

    // Signed immediate before extension
    typedef logic [`LSU_IMM_W-1:0] imm_t;

    // Access width, same encoding as funct3 of loads and stores
    typedef logic [2:0] ls_width_t;

    // One enable per byte lane of a doubleword
    typedef logic [7:0] byte_en_t;

    // Exception cause as written to mcause
    typedef logic [4:0] exc_code_t;

    // ------------------------------------------------------------
    // Access width codes
    // ------------------------------------------------------------
    localparam ls_width_t LS_BYTE   = 3'd0;
    localparam ls_width_t LS_HALF   = 3'd1;
    localparam ls_width_t LS_WORD   = 3'd2;
    localparam ls_width_t LS_DOUBLE = 3'd3;
    // Zero-extending variants, loads only
    localparam ls_width_t LS_BYTE_U = 3'd4;
    localparam ls_width_t LS_HALF_U = 3'd5;
    localparam ls_width_t LS_WORD_U = 3'd6;

    // Exception causes, only misalignment without virtual memory
    localparam exc_code_t EXC_LD_MISALIGNED = 5'd4;
    localparam exc_code_t EXC_ST_MISALIGNED = 5'd6;

    // Fill level of a spill cell
    typedef enum logic [1:0] {
        SPILL_EMPTY,
        SPILL_ONE,
        SPILL_TWO
    } spill_state_t;

endpackage

/* design/lsu_stage_if.sv */
`timescale 1ns/100ps

// Request from the issue stage to the address adder
interface agu_req_if;
    import lsu_pkg::*;

    logic      valid;
    logic      ready;
    tag_t      tag;
    logic      is_store;
    ls_width_t width;
    // Base register value and sign-extended offset
    xlen_t     base;
    xlen_t     offs;
    xlen_t     wdata;

    modport src (output valid, tag, is_store, width, base, offs, wdata, input ready);
    modport dst (input valid, tag, is_store, width, base, offs, wdata, output ready);
endinterface

// Answer from the address adder to the memory-request stage
interface agu_ans_if;
    import lsu_pkg::*;

    logic      valid;
    logic      ready;
    tag_t      tag;
    logic      is_store;
    ls_width_t width;
    xlen_t     addr;
    xlen_t     wdata;
    logic      except_raised;
    exc_code_t except_code;

    modport src (output valid, tag, is_store, width, addr, wdata, except_raised,
                 except_code, input ready);
    modport dst (input valid, tag, is_store, width, addr, wdata, except_raised,
                 except_code, output ready);
endinterface

/* design/spill_cell.sv */
`timescale 1ns/100ps

module spill_cell #(
    parameter int unsigned DATA_W = 8
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              flush_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  logic [DATA_W-1:0] data_i,
    output logic              valid_o,
    input  logic              ready_i,
    output logic [DATA_W-1:0] data_o
);
    import lsu_pkg::*;

    spill_state_t      state_q;
    spill_state_t      state_d;
    // Output entry and the skid entry behind it
    logic [DATA_W-1:0] main_q;
    logic [DATA_W-1:0] skid_q;
    logic              valid_q;
    logic              ready_q;
    logic              push;
    logic              pop;

    assign push = valid_i & ready_q;
    assign pop  = valid_q & ready_i;

    // ------------------------------------------------------------
    // Fill state
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            SPILL_EMPTY: begin
                if (push) begin
                    state_d = SPILL_ONE;
                end
            end
            SPILL_ONE: begin
                // Push with pop keeps one entry
                if (push && !pop) begin
                    state_d = SPILL_TWO;
                end else if (!push && pop) begin
                    state_d = SPILL_EMPTY;
                end
            end
            SPILL_TWO: begin
                // Input is stalled here, only drain
                if (pop) begin
                    state_d = SPILL_ONE;
                end
            end
            default: state_d = SPILL_EMPTY;
        endcase
    end

    // Valid and ready are registered from the next state
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            state_q <= SPILL_EMPTY;
            valid_q <= 1'b0;
            ready_q <= 1'b1;
        end else begin
            state_q <= state_d;
            valid_q <= (state_d != SPILL_EMPTY);
            ready_q <= (state_d != SPILL_TWO);
        end
    end

    // ------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (state_q == SPILL_TWO) begin
            // Skid entry moves up when the output drains
            if (pop) begin
                main_q <= skid_q;
            end
        end else if (push) begin
            if (state_q == SPILL_EMPTY || pop) begin
                main_q <= data_i;
            end else begin
                skid_q <= data_i;
            end
        end
    end

    assign valid_o = valid_q;
    assign ready_o = ready_q;
    assign data_o  = main_q;

endmodule

/* design/lsu_issue_stage.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_issue_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              flush_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  lsu_pkg::tag_t     tag_i,
    input  logic              is_store_i,
    input  lsu_pkg::ls_width_t width_i,
    input  lsu_pkg::xlen_t    base_i,
    input  lsu_pkg::imm_t     imm_i,
    input  lsu_pkg::xlen_t    wdata_i,
    agu_req_if.src            req_o
);
    import lsu_pkg::*;

    // Packed request: tag, store flag, width, base, offset, data
    localparam int unsigned REQ_W = $bits(tag_t) + 1 + $bits(ls_width_t) + 3 * $bits(xlen_t);

    ls_width_t        width_dec;
    xlen_t            offs;
    logic [REQ_W-1:0] req_pkt;
    logic [REQ_W-1:0] req_reg;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    // Replicate the immediate sign bit up to the full word
    assign offs = {{(`LSU_XLEN - `LSU_IMM_W){imm_i[`LSU_IMM_W-1]}}, imm_i};

    // Stores have no unsigned variant, so the extension bit is dropped
    always_comb begin
        width_dec = width_i;
        if (is_store_i && width_i[2]) begin
            width_dec = {1'b0, width_i[1:0]};
        end
    end

    assign req_pkt = {tag_i, is_store_i, width_dec, base_i, offs, wdata_i};

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    spill_cell #(
        .DATA_W (REQ_W)
    ) u_issue_reg (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .data_i  (req_pkt),
        .valid_o (req_o.valid),
        .ready_i (req_o.ready),
        .data_o  (req_reg)
    );

    // Unpack onto the stage interface
    assign {req_o.tag, req_o.is_store, req_o.width, req_o.base, req_o.offs, req_o.wdata} =
        req_reg;

endmodule

/* design/address_adder.sv */
`timescale 1ns/100ps

module address_adder (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   flush_i,
    agu_req_if.dst req_i,
    agu_ans_if.src ans_o
);
    import lsu_pkg::*;

    // Packed answer: tag, store flag, width, address, data, exception
    localparam int unsigned ANS_W = $bits(tag_t) + 1 + $bits(ls_width_t) + 2 * $bits(xlen_t)
                                    + 1 + $bits(exc_code_t);

    xlen_t            addr;
    logic             misaligned;
    exc_code_t        cause;
    logic [ANS_W-1:0] ans_pkt;
    logic [ANS_W-1:0] ans_reg;

    // ------------------------------------------------------------
    // Address and alignment
    // ------------------------------------------------------------

    // Plain physical address, wraps modulo 2^64
    assign addr = req_i.base + req_i.offs;

    // Natural alignment by access size, bytes never fault
    always_comb begin
        case (req_i.width)
            LS_HALF, LS_HALF_U: misaligned = addr[0];
            LS_WORD, LS_WORD_U: misaligned = (addr[1:0] != 2'b00);
            LS_DOUBLE:          misaligned = (addr[2:0] != 3'b000);
            default:            misaligned = 1'b0;
        endcase
    end

    // Without virtual memory misalignment is the only cause left
    assign cause = req_i.is_store ? EXC_ST_MISALIGNED : EXC_LD_MISALIGNED;

    assign ans_pkt = {req_i.tag, req_i.is_store, req_i.width, addr, req_i.wdata,
                      misaligned, cause};

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    spill_cell #(
        .DATA_W (ANS_W)
    ) u_adder_reg (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (req_i.valid),
        .ready_o (req_i.ready),
        .data_i  (ans_pkt),
        .valid_o (ans_o.valid),
        .ready_i (ans_o.ready),
        .data_o  (ans_reg)
    );

    assign {ans_o.tag, ans_o.is_store, ans_o.width, ans_o.addr, ans_o.wdata,
            ans_o.except_raised, ans_o.except_code} = ans_reg;

endmodule

/* design/mem_req_stage.sv */
`timescale 1ns/100ps

module mem_req_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                flush_i,
    agu_ans_if.dst              ans_i,
    output logic                valid_o,
    input  logic                ready_i,
    output lsu_pkg::tag_t       tag_o,
    output lsu_pkg::xlen_t      addr_o,
    output lsu_pkg::byte_en_t   be_o,
    output lsu_pkg::xlen_t      wdata_o,
    output logic                we_o,
    output logic                except_o,
    output lsu_pkg::exc_code_t  except_code_o
);
    import lsu_pkg::*;

    // Packed memory request: tag, address, enables, data, write, exception
    localparam int unsigned MEM_W = $bits(tag_t) + 2 * $bits(xlen_t) + $bits(byte_en_t)
                                    + 2 + $bits(exc_code_t);

    logic [2:0]       lane;
    byte_en_t         be_base;
    byte_en_t         be;
    xlen_t            wdata;
    logic             we;
    logic [MEM_W-1:0] mem_pkt;
    logic [MEM_W-1:0] mem_reg;

    // Byte offset inside the doubleword
    assign lane = ans_i.addr[2:0];

    // ------------------------------------------------------------
    // Byte enables and store lanes
    // ------------------------------------------------------------

    // Unsigned codes share the size of their signed partner
    always_comb begin
        case (ans_i.width[1:0])
            2'b00:   be_base = 8'b0000_0001;
            2'b01:   be_base = 8'b0000_0011;
            2'b10:   be_base = 8'b0000_1111;
            default: be_base = 8'b1111_1111;
        endcase
    end

    always_comb begin
        be    = be_base << lane;
        // Bytes pushed past lane 7 fall off the top
        wdata = ans_i.wdata << {lane, 3'b000};
        we    = ans_i.is_store;
        // A faulting access must not touch memory
        if (ans_i.except_raised) begin
            be    = '0;
            wdata = '0;
            we    = 1'b0;
        end
    end

    assign mem_pkt = {ans_i.tag, ans_i.addr, be, wdata, we, ans_i.except_raised,
                      ans_i.except_code};

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    spill_cell #(
        .DATA_W (MEM_W)
    ) u_mem_reg (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (ans_i.valid),
        .ready_o (ans_i.ready),
        .data_i  (mem_pkt),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .data_o  (mem_reg)
    );

    // Address goes out unchanged, also on exception
    assign {tag_o, addr_o, be_o, wdata_o, we_o, except_o, except_code_o} = mem_reg;

endmodule

/* design/lsu_agu_top.sv */
`timescale 1ns/100ps

module lsu_agu_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                flush_i,

    // Request from the load/store buffers
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  lsu_pkg::tag_t       req_tag_i,
    input  logic                req_is_store_i,
    input  lsu_pkg::ls_width_t  req_width_i,
    input  lsu_pkg::xlen_t      req_base_i,
    input  lsu_pkg::imm_t       req_imm_i,
    input  lsu_pkg::xlen_t      req_wdata_i,

    // Request towards memory, or exception response
    output logic                mem_valid_o,
    input  logic                mem_ready_i,
    output lsu_pkg::tag_t       mem_tag_o,
    output lsu_pkg::xlen_t      mem_addr_o,
    output lsu_pkg::byte_en_t   mem_be_o,
    output lsu_pkg::xlen_t      mem_wdata_o,
    output logic                mem_we_o,
    output logic                mem_except_o,
    output lsu_pkg::exc_code_t  mem_except_code_o
);

    // ------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------
    agu_req_if req_if ();
    agu_ans_if ans_if ();

    // Decode and immediate extension
    lsu_issue_stage u_issue (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .valid_i    (req_valid_i),
        .ready_o    (req_ready_o),
        .tag_i      (req_tag_i),
        .is_store_i (req_is_store_i),
        .width_i    (req_width_i),
        .base_i     (req_base_i),
        .imm_i      (req_imm_i),
        .wdata_i    (req_wdata_i),
        .req_o      (req_if.src)
    );

    // Effective address and alignment check
    address_adder u_adder (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .req_i   (req_if.dst),
        .ans_o   (ans_if.src)
    );

    // Byte lanes and memory request
    mem_req_stage u_mem_req (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .ans_i         (ans_if.dst),
        .valid_o       (mem_valid_o),
        .ready_i       (mem_ready_i),
        .tag_o         (mem_tag_o),
        .addr_o        (mem_addr_o),
        .be_o          (mem_be_o),
        .wdata_o       (mem_wdata_o),
        .we_o          (mem_we_o),
        .except_o      (mem_except_o),
        .except_code_o (mem_except_code_o)
    );

endmodule

/* verif/lsu_agu_sva.sv */
`timescale 1ns/100ps

module lsu_agu_sva (
    input logic               clk_i,
    input logic               reset_i,
    input logic               flush_i,
    input logic               req_valid_i,
    input logic               req_ready_o,
    input logic               mem_valid_o,
    input logic               mem_ready_i,
    input lsu_pkg::tag_t      mem_tag_o,
    input lsu_pkg::xlen_t     mem_addr_o,
    input lsu_pkg::byte_en_t  mem_be_o,
    input lsu_pkg::xlen_t     mem_wdata_o,
    input logic               mem_we_o,
    input logic               mem_except_o,
    input lsu_pkg::exc_code_t mem_except_code_o
);

    // Failed assertion count
    int unsigned fail_cnt = 0;

    // ------------------------------------------------------------
    // Reset
    // ------------------------------------------------------------

    // Memory side idle during reset and one edge after release
    reset_valid_low: assert property (@(posedge clk_i) reset_i |=> !mem_valid_o)
        else begin
            fail_cnt++;
            $error("mem_valid_o high after a reset edge");
        end

    // ------------------------------------------------------------
    // Output handshake
    // ------------------------------------------------------------

    // Stalled request keeps valid and payload
    hold_payload: assert property (@(posedge clk_i) disable iff (reset_i || flush_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o &&
        $stable({mem_tag_o, mem_addr_o, mem_be_o, mem_wdata_o, mem_we_o,
                 mem_except_o, mem_except_code_o}))
        else begin
            fail_cnt++;
            $error("memory request changed while stalled");
        end

    // Faulting access carries no enables and no write
    no_access_on_exc: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_valid_o && mem_except_o |-> mem_be_o == '0 && !mem_we_o)
        else begin
            fail_cnt++;
            $error("memory access on an exception response");
        end

    // Input ready only drops after a push filled the issue cell
    ready_falls_on_push: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(req_ready_o) && !$past(flush_i) |-> $past(req_valid_i))
        else begin
            fail_cnt++;
            $error("req_ready_o fell without an incoming request");
        end

endmodule

bind lsu_agu_top lsu_agu_sva sva_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .flush_i           (flush_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .mem_valid_o       (mem_valid_o),
    .mem_ready_i       (mem_ready_i),
    .mem_tag_o         (mem_tag_o),
    .mem_addr_o        (mem_addr_o),
    .mem_be_o          (mem_be_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_we_o          (mem_we_o),
    .mem_except_o      (mem_except_o),
    .mem_except_code_o (mem_except_code_o)
);

/* verif/lsu_agu_tb.sv */
`timescale 1ns/100ps

module lsu_agu_tb;
    import lsu_pkg::*;

    localparam int TIMEOUT = 200;

    // Expected memory-side response
    typedef struct packed {
        tag_t      tag;
        xlen_t     addr;
        byte_en_t  be;
        xlen_t     wdata;
        logic      we;
        logic      exc;
        exc_code_t code;
    } resp_t;

    logic      clk_i;
    logic      reset_i;
    logic      flush_i;
    logic      req_valid_i;
    logic      req_ready_o;
    tag_t      req_tag_i;
    logic      req_is_store_i;
    ls_width_t req_width_i;
    xlen_t     req_base_i;
    imm_t      req_imm_i;
    xlen_t     req_wdata_i;
    logic      mem_valid_o;
    logic      mem_ready_i;
    tag_t      mem_tag_o;
    xlen_t     mem_addr_o;
    byte_en_t  mem_be_o;
    xlen_t     mem_wdata_o;
    logic      mem_we_o;
    logic      mem_except_o;
    exc_code_t mem_except_code_o;

    logic [15:0] lfsr_q = 16'd78;
    resp_t       exp_q[$];
    string       test_name;
    int          err_cnt;
    int          err_mark;
    int          resp_cnt;
    int          tests_run;
    int          tests_failed;

    lsu_agu_top dut_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .flush_i           (flush_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .req_tag_i         (req_tag_i),
        .req_is_store_i    (req_is_store_i),
        .req_width_i       (req_width_i),
        .req_base_i        (req_base_i),
        .req_imm_i         (req_imm_i),
        .req_wdata_i       (req_wdata_i),
        .mem_valid_o       (mem_valid_o),
        .mem_ready_i       (mem_ready_i),
        .mem_tag_o         (mem_tag_o),
        .mem_addr_o        (mem_addr_o),
        .mem_be_o          (mem_be_o),
        .mem_wdata_o       (mem_wdata_o),
        .mem_we_o          (mem_we_o),
        .mem_except_o      (mem_except_o),
        .mem_except_code_o (mem_except_code_o)
    );

    // 20 ns clock
    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Random bits and reference model
    // ------------------------------------------------------------

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic xlen_t rand_bits(int unsigned n);
        xlen_t val;
        logic  fb;
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[62:0], fb};
        end
        return val;
    endfunction

    function automatic resp_t model_resp(tag_t tag, logic is_store, ls_width_t width,
                                         xlen_t base, imm_t imm, xlen_t wdata);
        resp_t       r;
        xlen_t       offs;
        int unsigned size;
        int unsigned lane;
        // Signed immediate widened to the full word
        offs = $signed(imm);
        case (width)
            LS_BYTE, LS_BYTE_U: size = 1;
            LS_HALF, LS_HALF_U: size = 2;
            LS_WORD, LS_WORD_U: size = 4;
            default:            size = 8;
        endcase
        r.tag   = tag;
        r.addr  = base + offs;
        lane    = int'(r.addr[2:0]);
        r.exc   = (lane % size) != 0;
        r.code  = is_store ? EXC_ST_MISALIGNED : EXC_LD_MISALIGNED;
        r.be    = '0;
        r.wdata = '0;
        r.we    = 1'b0;
        // Nothing reaches memory on a fault
        if (!r.exc) begin
            r.we = is_store;
            for (int unsigned b = 0; b < 8; b++) begin
                if (b >= lane && b < lane + size) begin
                    r.be[b] = 1'b1;
                end
                if (b >= lane) begin
                    r.wdata[8*b +: 8] = wdata[8*(b-lane) +: 8];
                end
            end
        end
        return r;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_addr(string what, xlen_t exp, xlen_t act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_data(string what, xlen_t exp, xlen_t act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_be(string what, byte_en_t exp, byte_en_t act);
        if (exp !== act) begin
            $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_code(string what, exc_code_t exp, exc_code_t act);
        if (exp !== act) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_tag(string what, tag_t exp, tag_t act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    // Output monitor, one expected entry per memory-side transfer
    always @(posedge clk_i) begin
        resp_t exp;
        if (!reset_i && mem_valid_o && mem_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("%s: memory request with no request outstanding", test_name);
                err_cnt++;
            end else begin
                exp = exp_q.pop_front();
                resp_cnt++;
                check_tag("tag", exp.tag, mem_tag_o);
                check_addr("addr", exp.addr, mem_addr_o);
                check_be("be", exp.be, mem_be_o);
                check_data("wdata", exp.wdata, mem_wdata_o);
                check_flag("we", exp.we, mem_we_o);
                check_flag("except", exp.exc, mem_except_o);
                if (exp.exc) begin
                    check_code("cause", exp.code, mem_except_code_o);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------

    // Hold one request until the issue stage takes it
    task automatic send_req(tag_t tag, logic is_store, ls_width_t width, xlen_t base,
                            imm_t imm, xlen_t wdata);
        int cycles;
        exp_q.push_back(model_resp(tag, is_store, width, base, imm, wdata));
        req_valid_i    = 1'b1;
        req_tag_i      = tag;
        req_is_store_i = is_store;
        req_width_i    = width;
        req_base_i     = base;
        req_imm_i      = imm;
        req_wdata_i    = wdata;
        cycles = 0;
        while (!req_ready_o && cycles < TIMEOUT) begin
            @(posedge clk_i);
            #2;
            cycles++;
        end
        if (!req_ready_o) begin
            $display("%s: timeout while waiting for req_ready_o", test_name);
            err_cnt++;
        end
        @(posedge clk_i);
        #2;
        req_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk_i);
            #2;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: timeout, %0d responses never arrived", test_name, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        err_mark  = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == err_mark) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, err_cnt - err_mark);
        end
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------

    // Every load code, negative offset on even codes
    task automatic test_aligned_loads();
        xlen_t base;
        imm_t  imm;
        start_test("test_aligned_loads");
        for (int w = 0; w < 7; w++) begin
            base    = rand_bits(61) << 3;
            imm     = imm_t'(rand_bits(8) << 3);
            imm[11] = (w % 2 == 0);
            send_req(tag_t'(w), 1'b0, ls_width_t'(w), base, imm, rand_bits(64));
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_store_lanes();
        xlen_t base;
        start_test("test_store_lanes");
        for (int w = 0; w < 4; w++) begin
            // Step through every aligned lane for this size
            for (int lane = 0; lane < 8; lane += (1 << w)) begin
                base = (rand_bits(61) << 3) | xlen_t'(lane);
                send_req(tag_t'(lane), 1'b1, ls_width_t'(w), base,
                         imm_t'(rand_bits(9) << 3), rand_bits(64));
            end
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_misaligned();
        xlen_t base;
        start_test("test_misaligned");
        for (int st = 0; st < 2; st++) begin
            // Stores only have the four signed codes
            for (int w = 0; w < (st == 1 ? 4 : 7); w++) begin
                // Every nonzero pattern of the low address bits
                for (int lane = 1; lane < 8; lane++) begin
                    base = (rand_bits(61) << 3) | xlen_t'(lane);
                    send_req(tag_t'(w), 1'(st), ls_width_t'(w), base,
                             imm_t'(rand_bits(9) << 3), rand_bits(64));
                end
            end
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_backpressure();
        logic      st_a[40];
        ls_width_t w_a[40];
        xlen_t     base_a[40];
        imm_t      imm_a[40];
        xlen_t     data_a[40];
        int        first_cnt;
        int        cycles;
        start_test("test_backpressure");
        first_cnt = resp_cnt;
        // Stimulus drawn up front so the ready toggler owns the LFSR
        for (int i = 0; i < 40; i++) begin
            st_a[i] = 1'(rand_bits(1));
            w_a[i]  = ls_width_t'(rand_bits(3));
            if (w_a[i] == 3'd7) begin
                w_a[i] = LS_DOUBLE;
            end
            base_a[i] = rand_bits(64);
            imm_a[i]  = imm_t'(rand_bits(12));
            data_a[i] = rand_bits(64);
        end
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    send_req(tag_t'(i), st_a[i], w_a[i], base_a[i], imm_a[i], data_a[i]);
                end
            end
            begin
                cycles = 0;
                while (resp_cnt - first_cnt < 40 && cycles < 10 * TIMEOUT) begin
                    mem_ready_i = 1'(rand_bits(1));
                    @(posedge clk_i);
                    #2;
                    cycles++;
                end
                if (resp_cnt - first_cnt < 40) begin
                    $display("%s: timeout while waiting for responses", test_name);
                    err_cnt++;
                end
                mem_ready_i = 1'b1;
            end
        join
        wait_drain();
        if (resp_cnt - first_cnt != 40) begin
            $display("Error: %s response count expected 40 actual %0d", test_name,
                     resp_cnt - first_cnt);
            err_cnt++;
        end
        end_test();
    endtask

    task automatic test_flush();
        start_test("test_flush");
        mem_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_req(tag_t'(8 + i), 1'b0, LS_DOUBLE, rand_bits(61) << 3, '0, '0);
        end
        @(posedge clk_i);
        #2;
        // One-cycle flush while the pipeline is stalled
        flush_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        exp_q.delete();
        mem_ready_i = 1'b1;
        for (int i = 0; i < 10; i++) begin
            if (mem_valid_o) begin
                $display("%s: flushed request reached the memory side", test_name);
                err_cnt++;
            end
            @(posedge clk_i);
            #2;
        end
        // Pipeline must work normally again
        send_req(4'hf, 1'b1, LS_WORD, rand_bits(61) << 3, imm_t'(12'h004), rand_bits(64));
        wait_drain();
        end_test();
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        reset_i        = 1'b1;
        flush_i        = 1'b0;
        req_valid_i    = 1'b0;
        req_tag_i      = '0;
        req_is_store_i = 1'b0;
        req_width_i    = LS_BYTE;
        req_base_i     = '0;
        req_imm_i      = '0;
        req_wdata_i    = '0;
        mem_ready_i    = 1'b1;
        test_name      = "reset";
        err_cnt        = 0;
        err_mark       = 0;
        resp_cnt       = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (16) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        test_aligned_loads();
        test_store_lanes();
        test_misaligned();
        test_backpressure();
        test_flush();
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, dut_i.sva_i.fail_cnt);
        if (err_cnt == 0 && dut_i.sva_i.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_stage_if.sv
design/spill_cell.sv
design/lsu_issue_stage.sv
design/address_adder.sv
design/mem_req_stage.sv
design/lsu_agu_top.sv
verif/lsu_agu_sva.sv
verif/lsu_agu_tb.sv
